// ==== logic/glb_pkg.sv ====
`default_nettype none

package glb_pkg;

    // Sizes --------------------
    localparam int unsigned num_banks = 4; // One bank per IO port.
    localparam int unsigned bank_data_width = 64;
    localparam int unsigned bank_strb_width = 8;
    localparam int unsigned cgra_data_width = 16;

    // Address fields --------------------
    localparam int unsigned glb_addr_width = 32;
    localparam int unsigned byte_offset_width = 3; // Byte within a 64-bit word.
    localparam int unsigned bank_addr_width = 12; // 4 KiB per bank.
    localparam int unsigned bank_word_addr_width = 9;
    localparam int unsigned bank_sel_width = 2; // Sits right above bank_addr_width.
    localparam int unsigned lane_width = 2; // Byte address bits 2 and 1.

endpackage

`default_nettype wire

// ==== logic/glb_bank.sv ====
`default_nettype none

module glb_bank (
    input  logic                                     clk,

    input  logic [glb_pkg::bank_strb_width-1:0]      host_wr_strb,
    input  logic [glb_pkg::bank_word_addr_width-1:0] host_addr,
    input  logic [glb_pkg::bank_data_width-1:0]      host_wr_data,
    input  logic                                     host_rd_en,
    output logic [glb_pkg::bank_data_width-1:0]      host_rd_data,

    input  logic [glb_pkg::bank_strb_width-1:0]      io_wr_strb,
    input  logic [glb_pkg::bank_word_addr_width-1:0] io_addr,
    input  logic [glb_pkg::bank_data_width-1:0]      io_wr_data,
    input  logic                                     io_rd_en,
    output logic [glb_pkg::bank_data_width-1:0]      io_rd_data
);
    import glb_pkg::*;

    logic [bank_data_width-1:0] mem [2**bank_word_addr_width];
    logic                       same_word;
    logic [bank_strb_width-1:0] io_strb_eff;

    // Host bytes win where both sides hit the same word.
    assign same_word   = host_addr == io_addr;
    assign io_strb_eff = same_word ? (io_wr_strb & ~host_wr_strb) : io_wr_strb;

    // Storage --------------------
    always_ff @(posedge clk) begin
        for (int b = 0; b < bank_strb_width; b++) begin
            if (host_wr_strb[b]) begin
                mem[host_addr][8*b +: 8] <= host_wr_data[8*b +: 8];
            end
            if (io_strb_eff[b]) begin
                mem[io_addr][8*b +: 8] <= io_wr_data[8*b +: 8];
            end
        end
    end

    // Registered reads, old data on a same-cycle write.
    always_ff @(posedge clk) begin
        if (host_rd_en) begin
            host_rd_data <= mem[host_addr];
        end
        if (io_rd_en) begin
            io_rd_data <= mem[io_addr];
        end
    end

    // Checks --------------------
    a_host_addr_known: assert property (
        @(posedge clk) (host_rd_en || (|host_wr_strb)) |-> !$isunknown(host_addr)
    ) else $error("glb_bank: host access with unknown address");

    a_io_addr_known: assert property (
        @(posedge clk) (io_rd_en || (|io_wr_strb)) |-> !$isunknown(io_addr)
    ) else $error("glb_bank: io access with unknown address");

endmodule

`default_nettype wire

// ==== logic/glb_host_port.sv ====
`default_nettype none

module glb_host_port (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic [glb_pkg::bank_strb_width-1:0]      host_wr_strb,
    input  logic [glb_pkg::glb_addr_width-1:0]       host_wr_addr,
    input  logic [glb_pkg::bank_data_width-1:0]      host_wr_data,
    input  logic                                     host_rd_en,
    input  logic [glb_pkg::glb_addr_width-1:0]       host_rd_addr,
    output logic [glb_pkg::bank_data_width-1:0]      host_rd_data,

    output logic [glb_pkg::bank_strb_width-1:0]      bank_wr_strb [glb_pkg::num_banks-1:0],
    output logic [glb_pkg::bank_word_addr_width-1:0] bank_addr,
    output logic [glb_pkg::bank_data_width-1:0]      bank_wr_data,
    output logic [glb_pkg::num_banks-1:0]            bank_rd_en,
    input  logic [glb_pkg::bank_data_width-1:0]      bank_rd_data [glb_pkg::num_banks-1:0]
);
    import glb_pkg::*;

    logic [bank_sel_width-1:0] wr_sel;
    logic [bank_sel_width-1:0] rd_sel;
    logic                      rd_pending;
    logic [bank_sel_width-1:0] rd_bank;

    // Address decode --------------------
    assign wr_sel = host_wr_addr[bank_addr_width +: bank_sel_width];
    assign rd_sel = host_rd_addr[bank_addr_width +: bank_sel_width];

    // Host side of a bank is single ported. A read takes the address.
    assign bank_addr = host_rd_en ? host_rd_addr[bank_addr_width-1:byte_offset_width]
                                  : host_wr_addr[bank_addr_width-1:byte_offset_width];
    assign bank_wr_data = host_wr_data;

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            bank_wr_strb[b] = (wr_sel == bank_sel_width'(b)) ? host_wr_strb : '0;
            bank_rd_en[b]   = host_rd_en && (rd_sel == bank_sel_width'(b));
        end
    end

    // Read return --------------------
    always_ff @(posedge clk) begin
        if (host_rd_en) begin
            rd_bank <= rd_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending   <= 1'b0;
            host_rd_data <= '0;
        end else begin
            rd_pending <= host_rd_en;
            if (rd_pending) begin
                host_rd_data <= bank_rd_data[rd_bank]; // Held until the next read.
            end
        end
    end

    // Checks --------------------
    a_one_bank_read: assert property (
        @(posedge clk) disable iff (rst) $onehot0(bank_rd_en)
    ) else $error("glb_host_port: more than one bank read enable");

    // Shared bank address cannot serve a read and a write at once.
    a_no_host_rd_wr: assert property (
        @(posedge clk) disable iff (rst) !(host_rd_en && (|host_wr_strb))
    ) else $error("glb_host_port: host read and write in the same cycle");

endmodule

`default_nettype wire

// ==== logic/glb_io_port.sv ====
`default_nettype none

module glb_io_port (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     stall,

    input  logic                                     wr_en,
    input  logic                                     rd_en,
    input  logic [glb_pkg::cgra_data_width-1:0]      wr_data,
    input  logic [glb_pkg::cgra_data_width-1:0]      addr_high,
    input  logic [glb_pkg::cgra_data_width-1:0]      addr_low,
    output logic [glb_pkg::cgra_data_width-1:0]      rd_data,
    output logic                                     rd_data_valid,

    output logic [glb_pkg::bank_strb_width-1:0]      bank_wr_strb,
    output logic [glb_pkg::bank_word_addr_width-1:0] bank_addr,
    output logic [glb_pkg::bank_data_width-1:0]      bank_wr_data,
    output logic                                     bank_rd_en,
    input  logic [glb_pkg::bank_data_width-1:0]      bank_rd_data
);
    import glb_pkg::*;

    logic [glb_addr_width-1:0]  byte_addr;
    logic [lane_width-1:0]      lane;
    logic                       wr_accept;
    logic                       rd_accept;
    logic                       rd_pending;
    logic [lane_width-1:0]      rd_lane;

    // Request side --------------------
    assign byte_addr = {addr_high, addr_low};
    assign lane      = byte_addr[byte_offset_width-1:1];
    assign bank_addr = byte_addr[bank_addr_width-1:byte_offset_width];

    // Stall freezes new traffic only.
    assign wr_accept = wr_en && !stall;
    assign rd_accept = rd_en && !stall;

    assign bank_wr_data = {(bank_data_width / cgra_data_width){wr_data}};
    assign bank_wr_strb = wr_accept ? (bank_strb_width'(2'b11) << {lane, 1'b0}) : '0;
    assign bank_rd_en   = rd_accept;

    // Return side --------------------
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_lane <= lane;
        end
        if (rd_pending) begin
            rd_data <= bank_rd_data[rd_lane*cgra_data_width +: cgra_data_width];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending    <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            rd_pending    <= rd_accept;
            rd_data_valid <= rd_pending; // Bank data lands one cycle after issue.
        end
    end

    // Checks --------------------
    a_valid_after_read: assert property (
        @(posedge clk) disable iff (rst) rd_data_valid |-> $past(rd_accept, 2)
    ) else $error("glb_io_port: read valid without an accepted read");

endmodule

`default_nettype wire

// ==== logic/global_buffer.sv ====
`default_nettype none

module global_buffer (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [glb_pkg::bank_strb_width-1:0] host_wr_strb,
    input  logic [glb_pkg::glb_addr_width-1:0]  host_wr_addr,
    input  logic [glb_pkg::bank_data_width-1:0] host_wr_data,

    input  logic                                host_rd_en,
    input  logic [glb_pkg::glb_addr_width-1:0]  host_rd_addr,
    output logic [glb_pkg::bank_data_width-1:0] host_rd_data,

    input  logic                                cgra_to_io_wr_en [glb_pkg::num_banks-1:0],
    input  logic                                cgra_to_io_rd_en [glb_pkg::num_banks-1:0],
    input  logic [glb_pkg::cgra_data_width-1:0] cgra_to_io_wr_data [glb_pkg::num_banks-1:0],
    input  logic [glb_pkg::cgra_data_width-1:0] cgra_to_io_addr_high [glb_pkg::num_banks-1:0],
    input  logic [glb_pkg::cgra_data_width-1:0] cgra_to_io_addr_low [glb_pkg::num_banks-1:0],
    output logic [glb_pkg::cgra_data_width-1:0] io_to_cgra_rd_data [glb_pkg::num_banks-1:0],
    output logic                                io_to_cgra_rd_data_valid [glb_pkg::num_banks-1:0],

    input  logic                                glc_to_io_stall
);
    import glb_pkg::*;

    // Host side of the banks.
    logic [bank_strb_width-1:0]      host_bank_wr_strb [num_banks-1:0];
    logic [bank_word_addr_width-1:0] host_bank_addr;
    logic [bank_data_width-1:0]      host_bank_wr_data;
    logic [num_banks-1:0]            host_bank_rd_en;
    logic [bank_data_width-1:0]      host_bank_rd_data [num_banks-1:0];

    // IO side of the banks.
    logic [bank_strb_width-1:0]      io_bank_wr_strb [num_banks-1:0];
    logic [bank_word_addr_width-1:0] io_bank_addr [num_banks-1:0];
    logic [bank_data_width-1:0]      io_bank_wr_data [num_banks-1:0];
    logic [num_banks-1:0]            io_bank_rd_en;
    logic [bank_data_width-1:0]      io_bank_rd_data [num_banks-1:0];

    // Host port --------------------
    glb_host_port u_host_port (
        .clk          (clk),
        .rst          (rst),
        .host_wr_strb (host_wr_strb),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .host_rd_en   (host_rd_en),
        .host_rd_addr (host_rd_addr),
        .host_rd_data (host_rd_data),
        .bank_wr_strb (host_bank_wr_strb),
        .bank_addr    (host_bank_addr),
        .bank_wr_data (host_bank_wr_data),
        .bank_rd_en   (host_bank_rd_en),
        .bank_rd_data (host_bank_rd_data)
    );

    // IO ports and banks --------------------
    for (genvar i = 0; i < num_banks; i++) begin : g_tile
        glb_io_port u_io_port (
            .clk           (clk),
            .rst           (rst),
            .stall         (glc_to_io_stall),
            .wr_en         (cgra_to_io_wr_en[i]),
            .rd_en         (cgra_to_io_rd_en[i]),
            .wr_data       (cgra_to_io_wr_data[i]),
            .addr_high     (cgra_to_io_addr_high[i]),
            .addr_low      (cgra_to_io_addr_low[i]),
            .rd_data       (io_to_cgra_rd_data[i]),
            .rd_data_valid (io_to_cgra_rd_data_valid[i]),
            .bank_wr_strb  (io_bank_wr_strb[i]),
            .bank_addr     (io_bank_addr[i]),
            .bank_wr_data  (io_bank_wr_data[i]),
            .bank_rd_en    (io_bank_rd_en[i]),
            .bank_rd_data  (io_bank_rd_data[i])
        );

        glb_bank u_bank (
            .clk          (clk),
            .host_wr_strb (host_bank_wr_strb[i]),
            .host_addr    (host_bank_addr),
            .host_wr_data (host_bank_wr_data),
            .host_rd_en   (host_bank_rd_en[i]),
            .host_rd_data (host_bank_rd_data[i]),
            .io_wr_strb   (io_bank_wr_strb[i]),
            .io_addr      (io_bank_addr[i]),
            .io_wr_data   (io_bank_wr_data[i]),
            .io_rd_en     (io_bank_rd_en[i]),
            .io_rd_data   (io_bank_rd_data[i])
        );
    end

endmodule

`default_nettype wire

// ==== dv/glb_ref_model.svh ====
`ifndef GLB_REF_MODEL_SVH
`define GLB_REF_MODEL_SVH

// Byte image of every bank, indexed by bank and in-bank byte address.
logic [7:0] model_mem [num_banks][2**bank_addr_width];

function automatic int word_base(input logic [glb_addr_width-1:0] addr);
    return int'(addr[bank_addr_width-1:byte_offset_width]) * bank_strb_width;
endfunction

// Lane l covers bytes 2l and 2l+1, low byte first.
function automatic int lane_base(input logic [glb_addr_width-1:0] addr);
    return word_base(addr) + 2 * int'(addr[byte_offset_width-1:1]);
endfunction

task automatic model_host_write(input logic [glb_addr_width-1:0] addr,
                                input logic [bank_strb_width-1:0] strb,
                                input logic [bank_data_width-1:0] data);
    int base;
    base = word_base(addr);
    for (int b = 0; b < bank_strb_width; b++) begin
        if (strb[b]) begin
            model_mem[addr[bank_addr_width +: bank_sel_width]][base + b] = data[8*b +: 8];
        end
    end
endtask

function automatic logic [bank_data_width-1:0] model_host_read(
    input logic [glb_addr_width-1:0] addr);
    logic [bank_data_width-1:0] word;
    int base;
    base = word_base(addr);
    for (int b = 0; b < bank_strb_width; b++) begin
        word[8*b +: 8] = model_mem[addr[bank_addr_width +: bank_sel_width]][base + b];
    end
    return word;
endfunction

task automatic model_io_write(input int port, input logic [glb_addr_width-1:0] addr,
                              input logic [cgra_data_width-1:0] data);
    int base;
    base = lane_base(addr);
    model_mem[port][base]     = data[7:0];
    model_mem[port][base + 1] = data[15:8];
endtask

function automatic logic [cgra_data_width-1:0] model_io_read(input int port,
    input logic [glb_addr_width-1:0] addr);
    int base;
    base = lane_base(addr);
    return {model_mem[port][base + 1], model_mem[port][base]};
endfunction

`endif

// ==== dv/tb_global_buffer.sv ====
`default_nettype none

module tb_global_buffer;
    import glb_pkg::*;

    localparam int unsigned seed = 32'hdee5_76ff;
    localparam int num_words = 16; // Test words per bank.
    localparam int preload_ops = num_banks * num_words;
    localparam int host_ops = 120;
    localparam int io_ops = 120;
    localparam int stall_ops = 100;
    localparam int clash_ops = 100;
    localparam int num_ops = 2 * preload_ops + host_ops + io_ops + stall_ops + clash_ops + 3;
    localparam int cycle_limit = 4 * num_ops + 100;

    logic                       clk;
    logic                       rst;
    logic [bank_strb_width-1:0] host_wr_strb;
    logic [glb_addr_width-1:0]  host_wr_addr;
    logic [bank_data_width-1:0] host_wr_data;
    logic                       host_rd_en;
    logic [glb_addr_width-1:0]  host_rd_addr;
    logic [bank_data_width-1:0] host_rd_data;
    logic                       cgra_to_io_wr_en [num_banks-1:0];
    logic                       cgra_to_io_rd_en [num_banks-1:0];
    logic [cgra_data_width-1:0] cgra_to_io_wr_data [num_banks-1:0];
    logic [cgra_data_width-1:0] cgra_to_io_addr_high [num_banks-1:0];
    logic [cgra_data_width-1:0] cgra_to_io_addr_low [num_banks-1:0];
    logic [cgra_data_width-1:0] io_to_cgra_rd_data [num_banks-1:0];
    logic                       io_to_cgra_rd_data_valid [num_banks-1:0];
    logic                       glc_to_io_stall;

    // Next cycle's stimulus as set up by the test phases.
    logic [bank_strb_width-1:0] nxt_host_wr_strb;
    logic [glb_addr_width-1:0]  nxt_host_wr_addr;
    logic [bank_data_width-1:0] nxt_host_wr_data;
    logic                       nxt_host_rd_en;
    logic [glb_addr_width-1:0]  nxt_host_rd_addr;
    logic                       nxt_io_wr_en [num_banks];
    logic                       nxt_io_rd_en [num_banks];
    logic [cgra_data_width-1:0] nxt_io_wr_data [num_banks];
    logic [glb_addr_width-1:0]  nxt_io_addr [num_banks];
    logic                       nxt_stall;

    // Ring of 4 expected-result slots indexed by issue cycle.
    logic                       host_due [4];
    logic [bank_data_width-1:0] host_exp [4];
    logic                       io_due [4][num_banks];
    logic [cgra_data_width-1:0] io_exp [4][num_banks];
    int                         cyc_idx = 0;
    int                         cycles = 0;

    `include "glb_ref_model.svh"

    global_buffer UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the test did not finish within %0d cycles.", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "Run stopped by the cycle limit.");
        end
    end

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at the first mismatch.");
    endtask

    function automatic logic [bank_word_addr_width-1:0] word_of(input int k);
        return bank_word_addr_width'(k * 37); // Spread over all index bits.
    endfunction

    function automatic logic [glb_addr_width-1:0] make_host_addr(input int bank, input int k);
        logic [glb_addr_width-1:0] a;
        a = $urandom; // Upper and byte offset bits are noise.
        a[bank_addr_width +: bank_sel_width] = bank_sel_width'(bank);
        a[bank_addr_width-1:byte_offset_width] = word_of(k);
        return a;
    endfunction

    function automatic logic [glb_addr_width-1:0] make_io_addr(input int k);
        logic [glb_addr_width-1:0] a;
        a = $urandom; // Lane comes from the random low bits.
        a[bank_addr_width-1:byte_offset_width] = word_of(k);
        return a;
    endfunction

    task automatic clear_stage();
        nxt_host_wr_strb = '0;
        nxt_host_wr_addr = '0;
        nxt_host_wr_data = '0;
        nxt_host_rd_en   = 1'b0;
        nxt_host_rd_addr = '0;
        nxt_stall        = 1'b0;
        for (int p = 0; p < num_banks; p++) begin
            nxt_io_wr_en[p]   = 1'b0;
            nxt_io_rd_en[p]   = 1'b0;
            nxt_io_wr_data[p] = '0;
            nxt_io_addr[p]    = '0;
        end
    endtask

    task automatic check_slot(input int c);
        if (host_due[c]) begin
            assert (host_rd_data === host_exp[c]) else report_mismatch($sformatf(
                "host read data %h, expected %h", host_rd_data, host_exp[c]));
        end
        for (int p = 0; p < num_banks; p++) begin
            assert (io_to_cgra_rd_data_valid[p] === io_due[c][p]) else report_mismatch(
                $sformatf("port %0d read valid %b, expected %b", p,
                          io_to_cgra_rd_data_valid[p], io_due[c][p]));
            if (io_due[c][p]) begin
                assert (io_to_cgra_rd_data[p] === io_exp[c][p]) else report_mismatch(
                    $sformatf("port %0d read data %h, expected %h", p,
                              io_to_cgra_rd_data[p], io_exp[c][p]));
            end
            io_due[c][p] = 1'b0;
        end
        host_due[c] = 1'b0;
    endtask

    // Drives one clock of stimulus and checks the reads issued two cycles before.
    task drive_cycle();
        int s;
        int c;
        s = cyc_idx % 4;
        c = (cyc_idx + 2) % 4;
        @(posedge clk);
        // Reads go first and see the data from before this cycle's writes.
        host_due[s] = nxt_host_rd_en;
        if (nxt_host_rd_en) begin
            host_exp[s] = model_host_read(nxt_host_rd_addr);
        end
        for (int p = 0; p < num_banks; p++) begin
            io_due[s][p] = nxt_io_rd_en[p] && !nxt_stall;
            if (io_due[s][p]) begin
                io_exp[s][p] = model_io_read(p, nxt_io_addr[p]);
            end
            if (nxt_io_wr_en[p] && !nxt_stall) begin
                model_io_write(p, nxt_io_addr[p], nxt_io_wr_data[p]);
            end
        end
        model_host_write(nxt_host_wr_addr, nxt_host_wr_strb, nxt_host_wr_data); // Host last.
        host_wr_strb    <= nxt_host_wr_strb;
        host_wr_addr    <= nxt_host_wr_addr;
        host_wr_data    <= nxt_host_wr_data;
        host_rd_en      <= nxt_host_rd_en;
        host_rd_addr    <= nxt_host_rd_addr;
        glc_to_io_stall <= nxt_stall;
        for (int p = 0; p < num_banks; p++) begin
            cgra_to_io_wr_en[p]     <= nxt_io_wr_en[p];
            cgra_to_io_rd_en[p]     <= nxt_io_rd_en[p];
            cgra_to_io_wr_data[p]   <= nxt_io_wr_data[p];
            cgra_to_io_addr_high[p] <= nxt_io_addr[p][glb_addr_width-1:cgra_data_width];
            cgra_to_io_addr_low[p]  <= nxt_io_addr[p][cgra_data_width-1:0];
        end
        @(negedge clk);
        check_slot(c);
        cyc_idx++;
    endtask

    task automatic io_traffic(input int n, input bit stall_on);
        repeat (n) begin
            clear_stage();
            nxt_stall = stall_on && ($urandom % 3 != 0);
            for (int p = 0; p < num_banks; p++) begin
                nxt_io_wr_en[p]   = $urandom % 2 == 1;
                nxt_io_rd_en[p]   = $urandom % 2 == 1;
                nxt_io_wr_data[p] = cgra_data_width'($urandom);
                nxt_io_addr[p]    = make_io_addr($urandom % num_words);
            end
            if ($urandom % 4 == 0) begin
                nxt_host_rd_en   = 1'b1;
                nxt_host_rd_addr = make_host_addr($urandom % num_banks, $urandom % num_words);
            end
            drive_cycle();
        end
    endtask

    initial begin
        int unsigned seed_val;
        int b;
        int k;
        seed_val = $urandom(seed);
        rst = 1'b1;
        host_wr_strb = '0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd_en = 1'b0;
        host_rd_addr = '0;
        glc_to_io_stall = 1'b0;
        for (int p = 0; p < num_banks; p++) begin
            cgra_to_io_wr_en[p] = 1'b0;
            cgra_to_io_rd_en[p] = 1'b0;
            cgra_to_io_wr_data[p] = '0;
            cgra_to_io_addr_high[p] = '0;
            cgra_to_io_addr_low[p] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            host_due[i] = 1'b0;
            for (int p = 0; p < num_banks; p++) begin
                io_due[i][p] = 1'b0;
            end
        end
        clear_stage();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // Reset state --------------------
        assert (host_rd_data === '0) else report_mismatch("host read data not zero after reset");
        for (int p = 0; p < num_banks; p++) begin
            assert (io_to_cgra_rd_data_valid[p] === 1'b0) else report_mismatch(
                $sformatf("port %0d read valid high after reset", p));
        end

        // Fill the test words so every read has known data.
        for (b = 0; b < num_banks; b++) begin
            for (k = 0; k < num_words; k++) begin
                clear_stage();
                nxt_host_wr_strb = '1;
                nxt_host_wr_addr = make_host_addr(b, k);
                nxt_host_wr_data = {$urandom, $urandom};
                drive_cycle();
            end
        end

        // Host traffic --------------------
        repeat (host_ops) begin
            clear_stage();
            if ($urandom % 2 == 1) begin
                nxt_host_wr_strb = bank_strb_width'($urandom);
                nxt_host_wr_addr = make_host_addr($urandom % num_banks, $urandom % num_words);
                nxt_host_wr_data = {$urandom, $urandom};
            end else begin
                nxt_host_rd_en   = 1'b1;
                nxt_host_rd_addr = make_host_addr($urandom % num_banks, $urandom % num_words);
            end
            drive_cycle();
        end

        io_traffic(io_ops, 1'b0);
        io_traffic(stall_ops, 1'b1);

        // Host and IO on the same word --------------------
        repeat (clash_ops) begin
            clear_stage();
            b = $urandom % num_banks;
            k = $urandom % num_words;
            for (int p = 0; p < num_banks; p++) begin
                nxt_io_addr[p]    = make_io_addr((p == b) ? k : int'($urandom % num_words));
                nxt_io_wr_en[p]   = $urandom % 4 != 0;
                nxt_io_rd_en[p]   = $urandom % 2 == 1;
                nxt_io_wr_data[p] = cgra_data_width'($urandom);
            end
            if ($urandom % 3 != 0) begin
                nxt_host_wr_strb = bank_strb_width'($urandom);
                nxt_host_wr_addr = make_host_addr(b, k);
                nxt_host_wr_data = {$urandom, $urandom};
            end else begin
                nxt_host_rd_en   = 1'b1;
                nxt_host_rd_addr = make_host_addr(b, k);
            end
            drive_cycle();
        end

        // Final sweep of every test word.
        for (b = 0; b < num_banks; b++) begin
            for (k = 0; k < num_words; k++) begin
                clear_stage();
                nxt_host_rd_en   = 1'b1;
                nxt_host_rd_addr = make_host_addr(b, k);
                drive_cycle();
            end
        end
        clear_stage();
        repeat (3) drive_cycle(); // Drain pending reads.

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
logic/glb_pkg.sv
logic/glb_bank.sv
logic/glb_host_port.sv
logic/glb_io_port.sv
logic/global_buffer.sv
dv/tb_global_buffer.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the global buffer testbench with Verilator.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_global_buffer -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed."; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported a failure."; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "Simulation ended without a result."; exit 1; }
echo "Simulation finished cleanly."
